//--- all.f
+incdir+source
source/mem_pkg.sv
source/mem_port_if.sv
source/store_align.sv
source/load_align.sv
source/data_ram.sv
source/pwm_led_bank.sv
source/tick_timer.sv
source/bus_decoder.sv
source/mem_subsystem.sv
dv/tb_mem_subsystem.sv

//--- dv/tb_mem_subsystem.sv
// Testbench for the RV32I data-side memory subsystem
// Checks loads, stores, peripherals, PWM, timers and the req/ack handshake
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int RAND_ITERS  = 64;
    localparam int HOLD_CYCLES = 4;
    localparam int TIMER_GAP   = 150;
    localparam int HS_LIMIT    = 16;
    localparam int XFER_CYCLES = 12;
    localparam int NUM_XFERS   = RAND_ITERS * 6 + 48;
    localparam int MAX_CYCLES  = 8 + NUM_XFERS * (XFER_CYCLES + HOLD_CYCLES)
                                 + 2 * 256 + 2 * TIMER_GAP + 200;
    localparam int TICKS_US    = `MEM_CLK_FREQ_HZ / 1000000;
    localparam int TICKS_MS    = `MEM_CLK_FREQ_HZ / 1000;
    localparam int KIND_WORD   = 0;
    localparam int KIND_DUTY   = 1;
    localparam int KIND_COUNT  = 2;

    logic    clk;
    logic    rst;
    logic    req;
    logic    we;
    funct3_t funct3;
    word_t   addr;
    word_t   wdata;
    logic    ack;
    word_t   rdata;
    logic    led;
    logic    red;
    logic    green;
    logic    blue;

    // Shadow copies of data memory and the LED duty register
    byte_t shadow_mem [`MEM_DMEM_BYTES];
    word_t shadow_duty;
    word_t rng;
    int    cycle = 0;
    int    ack_cycle;
    int    checks;
    int    errors;
    int    chk0;
    int    err0;

    // Results waiting for the comparing process
    int    kind_q [$];
    word_t got_q [$];
    word_t exp_q [$];
    word_t hi_q [$];
    string what_q [$];

    mem_subsystem i_mem_subsystem (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .we     (we),
        .funct3 (funct3),
        .addr   (addr),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata),
        .led    (led),
        .red    (red),
        .green  (green),
        .blue   (blue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            abort_run("Run stopped: the cycle limit was reached before all tests finished");
        end
    end

    function automatic word_t next_rand();
        word_t x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Full word currently expected at an address, zero outside memory and LED
    function automatic word_t shadow_word(input word_t a);
        word_t w;
        int    base;
        w = '0;
        base = int'(a[11:0]) & ~3;
        if (a < `MEM_DMEM_BYTES) begin
            w = {shadow_mem[base + 3], shadow_mem[base + 2],
                 shadow_mem[base + 1], shadow_mem[base]};
        end else if ({a[31:2], 2'b00} == `MEM_LED_ADDR) begin
            w = shadow_duty;
        end
        return w;
    endfunction

    function automatic word_t load_expect(input funct3_t f3, input word_t a);
        word_t w;
        word_t sh;
        w  = shadow_word(a);
        sh = w >> (8 * a[1:0]);
        if (f3[1]) begin
            return w;
        end else if (f3[0]) begin
            return f3[2] ? {16'h0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
        end
        return f3[2] ? {24'h0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
    endfunction

    function automatic void store_apply(input funct3_t f3, input word_t a, input word_t d);
        int n;
        int lane;
        n = f3[1] ? 4 : (f3[0] ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            lane = int'(a[1:0]) + i;
            if (a < `MEM_DMEM_BYTES) begin
                shadow_mem[(int'(a[11:0]) & ~3) + lane] = d[8*i +: 8];
            end else if ({a[31:2], 2'b00} == `MEM_LED_ADDR) begin
                shadow_duty[8*lane +: 8] = d[8*i +: 8];
            end
        end
    endfunction

    function automatic word_t align_for(input funct3_t f3, input word_t a);
        if (f3[1]) begin
            return a & ~32'd3;
        end else if (f3[0]) begin
            return a & ~32'd1;
        end
        return a;
    endfunction

    function automatic void queue_check(input int kind, input word_t got, input word_t exp,
                                        input word_t hi, input string what);
        kind_q.push_back(kind);
        got_q.push_back(got);
        exp_q.push_back(exp);
        hi_q.push_back(hi);
        what_q.push_back(what);
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_duty(input duty_t got, input duty_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s gave %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input word_t got, input word_t lo, input word_t hi,
                               input string what);
        checks++;
        if (got < lo || got > hi) begin
            errors++;
            $display("FAILED at %0t ns: %s gave %0d, expected %0d to %0d",
                     $time, what, got, lo, hi);
        end
    endtask

    always @(posedge clk) begin : compare_results
        int    kind;
        word_t got;
        word_t exp;
        word_t hi;
        string what;
        while (kind_q.size() > 0) begin
            kind = kind_q.pop_front();
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            hi   = hi_q.pop_front();
            what = what_q.pop_front();
            case (kind)
                KIND_WORD: check_word(got, exp, what);
                KIND_DUTY: check_duty(duty_t'(got), duty_t'(exp), what);
                default:   check_count(got, exp, hi, what);
            endcase
        end
    end

    // One four-phase transfer, with req held for extra cycles after ack if asked
    task automatic bus_xfer(input logic wr, input funct3_t f3, input word_t a,
                            input word_t d, input int hold, input word_t hold_exp,
                            output word_t data);
        int waited;
        @(posedge clk);
        if (ack) begin
            errors++;
            $display("FAILED at %0t ns: ack high before req was raised", $time);
        end
        req    <= 1'b1;
        we     <= wr;
        funct3 <= f3;
        addr   <= a;
        wdata  <= d;
        waited = 0;
        while (!ack && waited < HS_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!ack) begin
            errors++;
            $display("Handshake timeout: no ack for the access to %h", a);
        end
        data = rdata;
        ack_cycle = cycle;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            if (!ack) begin
                errors++;
                $display("FAILED at %0t ns: ack dropped while req was held", $time);
            end
            queue_check(KIND_WORD, rdata, hold_exp, '0, "rdata while req held");
        end
        req <= 1'b0;
        waited = 0;
        while (ack && waited < HS_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (ack) begin
            errors++;
            $display("Handshake timeout: ack stayed high after req dropped at %h", a);
        end
    endtask

    task automatic do_store(input funct3_t f3, input word_t a, input word_t d);
        word_t got;
        bus_xfer(1'b1, f3, a, d, 0, '0, got);
        store_apply(f3, a, d);
        queue_check(KIND_WORD, got, '0, '0, $sformatf("write response at %h", a));
    endtask

    task automatic do_load(input funct3_t f3, input word_t a, input int hold);
        word_t got;
        word_t exp;
        exp = load_expect(f3, a);
        bus_xfer(1'b0, f3, a, next_rand(), hold, exp, got);
        queue_check(KIND_WORD, got, exp, '0,
                    $sformatf("load funct3 %0d at %h", f3, a));
    endtask

    task automatic read_timer(input word_t a, output word_t value);
        bus_xfer(1'b0, 3'd2, a, '0, 0, '0, value);
    endtask

    // Counts high cycles of each output over one full PWM period
    task automatic measure_pwm();
        int         high [4];
        logic [3:0] outs;
        for (int i = 0; i < 4; i++) begin
            high[i] = 0;
        end
        repeat (256) begin
            @(posedge clk);
            outs = {led, red, green, blue};
            for (int i = 0; i < 4; i++) begin
                high[i] += int'(outs[i]);
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (high[i] > 255) begin
                errors++;
                $display("FAILED at %0t ns: PWM lane %0d high on every cycle", $time, i);
            end
            queue_check(KIND_DUTY, word_t'(high[i]), word_t'(shadow_duty[8*i +: 8]), '0,
                        $sformatf("PWM lane %0d high cycles", i));
        end
    endtask

    task automatic end_test(input string name);
        while (kind_q.size() > 0) begin
            @(posedge clk);
        end
        $display("Test %s finished: %0d checks, %0d errors", name, checks - chk0, errors - err0);
        chk0 = checks;
        err0 = errors;
    endtask

    initial begin : stimulus
        word_t   a;
        word_t   prev;
        word_t   cur;
        word_t   v;
        funct3_t f3;
        int      t0;
        word_t   unmapped [3];
        rst    = 1'b1;
        req    = 1'b0;
        we     = 1'b0;
        funct3 = '0;
        addr   = '0;
        wdata  = '0;
        rng    = 32'd26;
        checks = 0;
        errors = 0;
        chk0   = 0;
        err0   = 0;
        shadow_duty = '0;
        for (int i = 0; i < `MEM_DMEM_BYTES; i++) begin
            shadow_mem[i] = '0;
        end
        unmapped[0] = 32'h0000_1000;
        unmapped[1] = 32'h8000_0000;
        unmapped[2] = 32'hFFFF_FFF0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int n = 0; n < RAND_ITERS; n++) begin
            f3 = funct3_t'(next_rand() % 3);
            a  = align_for(f3, next_rand() % `MEM_DMEM_BYTES);
            do_store(f3, a, next_rand());
            a = (a & ~32'd3) | (next_rand() & 32'd3);
            do_load(3'd2, align_for(3'd2, a), 0);
            do_load(3'd1, align_for(3'd1, a), 0);
            do_load(3'd5, align_for(3'd5, a), 0);
            do_load(3'd0, a, 0);
            do_load(3'd4, a, 0);
        end
        end_test("random stores and loads");

        do_store(3'd2, 32'h0000_0000, 32'h1234_5678);
        for (int i = 0; i < 3; i++) begin
            do_load(3'd2, unmapped[i], 0);
            do_store(3'd2, unmapped[i], next_rand());
        end
        do_load(3'd2, 32'h0000_0000, 0);
        do_load(3'd2, `MEM_LED_ADDR, 0);
        end_test("unmapped addresses");

        do_store(3'd0, `MEM_LED_ADDR + 1, 32'h0000_00A5);
        do_load(3'd2, `MEM_LED_ADDR, 0);
        do_store(3'd1, `MEM_LED_ADDR + 2, 32'h0000_C33C);
        do_load(3'd2, `MEM_LED_ADDR, 0);
        do_store(3'd0, `MEM_LED_ADDR, next_rand());
        do_store(3'd0, `MEM_LED_ADDR + 3, next_rand());
        do_load(3'd2, `MEM_LED_ADDR, 0);
        do_load(3'd4, `MEM_LED_ADDR + 2, 0);
        do_load(3'd5, `MEM_LED_ADDR + 2, 0);
        end_test("LED duty register");

        do_store(3'd2, `MEM_LED_ADDR, 32'hFF00_8001);
        measure_pwm();
        do_store(3'd2, `MEM_LED_ADDR, next_rand());
        measure_pwm();
        end_test("PWM outputs");

        read_timer(`MEM_MICROS_ADDR, prev);
        t0 = ack_cycle;
        repeat (TIMER_GAP) @(posedge clk);
        read_timer(`MEM_MICROS_ADDR, cur);
        queue_check(KIND_COUNT, cur - prev, '0, word_t'(1 + (ack_cycle - t0) / TICKS_US),
                    "micros step");
        prev = cur;
        t0   = ack_cycle;
        read_timer(`MEM_MILLIS_ADDR, v);
        queue_check(KIND_COUNT, v, '0, word_t'(1 + ack_cycle / TICKS_MS), "millis since reset");
        // Timer writes are ignored, so the counts keep running from where they were
        do_store(3'd2, `MEM_MICROS_ADDR, next_rand());
        do_store(3'd2, `MEM_MILLIS_ADDR, next_rand());
        read_timer(`MEM_MICROS_ADDR, cur);
        queue_check(KIND_COUNT, cur - prev, '0, word_t'(1 + (ack_cycle - t0) / TICKS_US),
                    "micros step after write");
        read_timer(`MEM_MILLIS_ADDR, v);
        queue_check(KIND_COUNT, v, '0, word_t'(1 + ack_cycle / TICKS_MS), "millis after write");
        end_test("timers");

        a = align_for(3'd2, next_rand() % `MEM_DMEM_BYTES);
        do_store(3'd2, a, next_rand());
        do_load(3'd2, a, HOLD_CYCLES);
        do_load(3'd0, a | 32'd1, HOLD_CYCLES);
        do_load(3'd2, `MEM_LED_ADDR, HOLD_CYCLES);
        end_test("handshake");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it
LOG=sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_subsystem -f all.f \
    -o tb_mem_subsystem > "$LOG" 2>&1 &&
    ./obj_dir/tb_mem_subsystem >> "$LOG" 2>&1 ||
    echo "*** TEST FAILED ***" >> "$LOG"
cat "$LOG"
grep -qF "*** TEST FAILED ***" "$LOG" && exit 1
exit 0

//--- source/bus_decoder.sv
// Bus decoder with four-phase req/ack handshake
// Captures a request, strobes the selected target and returns aligned read data
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module bus_decoder (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             req,
    input  wire logic             we,
    input  wire mem_pkg::funct3_t funct3,
    input  wire mem_pkg::word_t   addr,
    input  wire mem_pkg::word_t   wdata,
    output logic                  ack,
    output mem_pkg::word_t        rdata,
    mem_port_if.initiator         ram_port,
    mem_port_if.initiator         led_port,
    input  wire mem_pkg::word_t   millis,
    input  wire mem_pkg::word_t   micros
);
    import mem_pkg::*;

    bus_state_e state;

    // Request fields held from capture until the response
    logic       we_q;
    funct3_t    funct3_q;
    logic [1:0] offset_q;
    ram_addr_t  word_addr_q;
    word_t      wdata_q;
    logic       sel_ram_q;
    logic       sel_led_q;
    logic       sel_millis_q;
    logic       sel_micros_q;
    word_t      timer_q;

    logic       sel_ram;
    logic       sel_led;
    logic       sel_millis;
    logic       sel_micros;
    byte_en_t   byte_en;
    word_t      lane_data;
    word_t      raw_word;
    word_t      load_word;

    // Region decode on the live address, used only on the capturing edge
    assign sel_ram    = (addr < word_t'(`MEM_DMEM_BYTES));
    assign sel_led    = ({addr[31:2], 2'b00} == `MEM_LED_ADDR);
    assign sel_millis = ({addr[31:2], 2'b00} == `MEM_MILLIS_ADDR);
    assign sel_micros = ({addr[31:2], 2'b00} == `MEM_MICROS_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUS_IDLE;
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (req) begin
                        state <= BUS_ACCESS;
                    end
                end
                BUS_ACCESS: begin
                    state <= BUS_RESPOND;
                end
                BUS_RESPOND: begin
                    state <= BUS_HOLD;
                    ack   <= 1'b1;
                    rdata <= we_q ? '0 : load_word;
                end
                BUS_HOLD: begin
                    // Hold ack until the host lets go of req
                    if (!req) begin
                        state <= BUS_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: begin
                    state <= BUS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS_IDLE && req) begin
            we_q         <= we;
            funct3_q     <= funct3;
            offset_q     <= addr[1:0];
            word_addr_q  <= addr[11:2];
            wdata_q      <= wdata;
            sel_ram_q    <= sel_ram;
            sel_led_q    <= sel_led;
            sel_millis_q <= sel_millis;
            sel_micros_q <= sel_micros;
        end
        // Sample the running timer once per access
        if (state == BUS_ACCESS) begin
            timer_q <= sel_millis_q ? millis : micros;
        end
    end

    store_align u_store_align (
        .funct3    (funct3_q),
        .offset    (offset_q),
        .wdata     (wdata_q),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    assign ram_port.strobe    = (state == BUS_ACCESS) && sel_ram_q;
    assign ram_port.we        = we_q;
    assign ram_port.byte_en   = byte_en;
    assign ram_port.word_addr = word_addr_q;
    assign ram_port.wdata     = lane_data;

    assign led_port.strobe    = (state == BUS_ACCESS) && sel_led_q;
    assign led_port.we        = we_q;
    assign led_port.byte_en   = byte_en;
    assign led_port.word_addr = word_addr_q;
    assign led_port.wdata     = lane_data;

    // Unmapped regions read as zero, which stays zero after alignment
    always_comb begin
        if (sel_ram_q) begin
            raw_word = ram_port.rdata;
        end else if (sel_led_q) begin
            raw_word = led_port.rdata;
        end else if (sel_millis_q || sel_micros_q) begin
            raw_word = timer_q;
        end else begin
            raw_word = '0;
        end
    end

    load_align u_load_align (
        .funct3 (funct3_q),
        .offset (offset_q),
        .raw    (raw_word),
        .result (load_word)
    );

endmodule

`default_nettype wire

//--- source/data_ram.sv
// Data memory built from four byte-lane RAMs
// Lanes write under their byte enables and read the addressed word together
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module data_ram (
    input  wire logic  clk,
    mem_port_if.target port
);
    import mem_pkg::*;

    byte_t lane_rdata [4];

    for (genvar lane = 0; lane < 4; lane++) begin : g_lane
        byte_lane_ram u_lane (
            .clk       (clk),
            .wr        (port.strobe && port.we && port.byte_en[lane]),
            .word_addr (port.word_addr),
            .wdata     (port.wdata[8*lane +: 8]),
            .rdata     (lane_rdata[lane])
        );
    end

    assign port.rdata = {lane_rdata[3], lane_rdata[2], lane_rdata[1], lane_rdata[0]};

endmodule

// One byte lane of data memory with a registered read
module byte_lane_ram (
    input  wire logic               clk,
    input  wire logic               wr,
    input  wire mem_pkg::ram_addr_t word_addr,
    input  wire mem_pkg::byte_t     wdata,
    output mem_pkg::byte_t          rdata
);
    import mem_pkg::*;

    localparam int DEPTH = `MEM_DMEM_BYTES / 4;

    byte_t mem [DEPTH];

    // Memory starts out cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[word_addr] <= wdata;
        end
        rdata <= mem[word_addr];
    end

endmodule

`default_nettype wire

//--- source/load_align.sv
// Load alignment for word, half-word and byte loads
// Selects the addressed half or lane and sign- or zero-extends it
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire mem_pkg::funct3_t funct3,
    input  wire logic [1:0]       offset,
    input  wire mem_pkg::word_t   raw,
    output mem_pkg::word_t        result
);
    import mem_pkg::*;

    half_t half_sel;
    byte_t byte_sel;
    logic  zero_ext;

    assign zero_ext = funct3[2];
    assign half_sel = offset[1] ? raw[31:16] : raw[15:0];

    always_comb begin
        case (offset)
            2'd0:    byte_sel = raw[7:0];
            2'd1:    byte_sel = raw[15:8];
            2'd2:    byte_sel = raw[23:16];
            default: byte_sel = raw[31:24];
        endcase
    end

    always_comb begin
        if (funct3[1]) begin
            result = raw;
        end else if (funct3[0]) begin
            result = {{16{half_sel[15] & ~zero_ext}}, half_sel};
        end else begin
            result = {{24{byte_sel[7] & ~zero_ext}}, byte_sel};
        end
    end

endmodule

`default_nettype wire

//--- source/mem_params.svh
// Memory subsystem parameters
// Clock rate, memory size, peripheral addresses and PWM width
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// System clock rate in Hz, used to derive the timer prescales
`define MEM_CLK_FREQ_HZ 12000000

// Data memory size in bytes, starting at address zero
`define MEM_DMEM_BYTES 4096

// Peripheral word addresses at the top of the address space
`define MEM_LED_ADDR    32'hFFFF_FFFC
`define MEM_MILLIS_ADDR 32'hFFFF_FFF8
`define MEM_MICROS_ADDR 32'hFFFF_FFF4

// Width of a duty value and of the PWM counter
`define MEM_PWM_BITS 8

`endif

//--- source/mem_pkg.sv
// Memory subsystem types
// Bus vector types, RV32I width code and the handshake states
`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  duty_t;

    // RV32I load/store width code
    // Bit 1 selects a word, else bit 0 selects half-word over byte,
    // and bit 2 marks an unsigned load
    typedef logic [2:0] funct3_t;

    // One enable per byte lane, lane 0 is the least significant byte
    typedef logic [3:0] byte_en_t;

    // Word index into the 4 KiB data memory
    typedef logic [9:0] ram_addr_t;

    // Four-phase handshake controller states
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_ACCESS,
        BUS_RESPOND,
        BUS_HOLD
    } bus_state_e;

endpackage

`default_nettype wire

//--- source/mem_port_if.sv
// Fixed-latency target port between the bus decoder and one target
// A one-cycle strobe writes enabled lanes and reads the addressed word
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
    import mem_pkg::*;

    logic      strobe;
    logic      we;
    byte_en_t  byte_en;
    ram_addr_t word_addr;
    word_t     wdata;
    word_t     rdata;

    modport initiator (
        output strobe,
        output we,
        output byte_en,
        output word_addr,
        output wdata,
        input  rdata
    );

    modport target (
        input  strobe,
        input  we,
        input  byte_en,
        input  word_addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- source/mem_subsystem.sv
// RV32I data-side memory subsystem
// Data memory, LED PWM register and two elapsed-time timers behind a req/ack port
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module mem_subsystem (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            req,
    input  wire logic            we,
    input  wire mem_pkg::funct3_t funct3,
    input  wire mem_pkg::word_t   addr,
    input  wire mem_pkg::word_t   wdata,
    output logic                 ack,
    output mem_pkg::word_t       rdata,
    output logic                 led,
    output logic                 red,
    output logic                 green,
    output logic                 blue
);
    import mem_pkg::*;

    word_t millis_count;
    word_t micros_count;

    mem_port_if ram_port ();
    mem_port_if led_port ();

    bus_decoder u_bus_decoder (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .we       (we),
        .funct3   (funct3),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .rdata    (rdata),
        .ram_port (ram_port.initiator),
        .led_port (led_port.initiator),
        .millis   (millis_count),
        .micros   (micros_count)
    );

    data_ram u_data_ram (
        .clk  (clk),
        .port (ram_port.target)
    );

    pwm_led_bank u_pwm_led_bank (
        .clk   (clk),
        .rst   (rst),
        .port  (led_port.target),
        .led   (led),
        .red   (red),
        .green (green),
        .blue  (blue)
    );

    // One count per millisecond and per microsecond of the system clock
    tick_timer #(
        .TICKS_PER_COUNT (`MEM_CLK_FREQ_HZ / 1000)
    ) millis_timer (
        .clk   (clk),
        .rst   (rst),
        .count (millis_count)
    );

    tick_timer #(
        .TICKS_PER_COUNT (`MEM_CLK_FREQ_HZ / 1000000)
    ) micros_timer (
        .clk   (clk),
        .rst   (rst),
        .count (micros_count)
    );

endmodule

`default_nettype wire

//--- source/pwm_led_bank.sv
// LED duty register with four PWM outputs
// Blue, green, red and user LED duties sit in byte lanes 0 to 3
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module pwm_led_bank (
    input  wire logic  clk,
    input  wire logic  rst,
    mem_port_if.target port,
    output logic       led,
    output logic       red,
    output logic       green,
    output logic       blue
);
    import mem_pkg::*;

    word_t                   duty_q;
    logic [`MEM_PWM_BITS-1:0] pwm_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            duty_q <= '0;
        end else if (port.strobe && port.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (port.byte_en[lane]) begin
                    duty_q[8*lane +: 8] <= port.wdata[8*lane +: 8];
                end
            end
        end
    end

    assign port.rdata = duty_q;

    // Free-running counter shared by all four comparators
    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign blue  = pwm_cnt < duty_t'(duty_q[7:0]);
    assign green = pwm_cnt < duty_t'(duty_q[15:8]);
    assign red   = pwm_cnt < duty_t'(duty_q[23:16]);
    assign led   = pwm_cnt < duty_t'(duty_q[31:24]);

endmodule

`default_nettype wire

//--- source/store_align.sv
// Store alignment for word, half-word and byte stores
// Produces byte-lane enables and places the store data on its lanes
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire mem_pkg::funct3_t funct3,
    input  wire logic [1:0]       offset,
    input  wire mem_pkg::word_t   wdata,
    output mem_pkg::byte_en_t     byte_en,
    output mem_pkg::word_t        lane_data
);
    import mem_pkg::*;

    always_comb begin
        if (funct3[1]) begin
            byte_en   = 4'b1111;
            lane_data = wdata;
        end else if (funct3[0]) begin
            // Half-word goes to the lower or upper pair of lanes
            byte_en   = offset[1] ? 4'b1100 : 4'b0011;
            lane_data = {wdata[15:0], wdata[15:0]};
        end else begin
            byte_en   = byte_en_t'(4'b0001 << offset);
            lane_data = {4{wdata[7:0]}};
        end
    end

endmodule

`default_nettype wire

//--- source/tick_timer.sv
// Prescaled elapsed-time counter
// Counts up once every TICKS_PER_COUNT clocks, wrapping at 2^32
`timescale 1ns/1ps
`default_nettype none

module tick_timer #(
    parameter int unsigned TICKS_PER_COUNT = 12
) (
    input  wire logic      clk,
    input  wire logic      rst,
    output mem_pkg::word_t count
);
    import mem_pkg::*;

    // Keep at least one prescaler bit when the count runs every cycle
    localparam int PRE_W = (TICKS_PER_COUNT > 1) ? $clog2(TICKS_PER_COUNT) : 1;

    logic [PRE_W-1:0] prescale;

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            count    <= '0;
        end else if (prescale == PRE_W'(TICKS_PER_COUNT - 1)) begin
            prescale <= '0;
            count    <= count + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

`default_nettype wire
